// ==== mctl_assertions.sv ====
////////////////////
// Concurrent checks on the register
// file and the watchdog, plus binds
////////////////////

`timescale 1ns/1ps

`include "mctl_config.svh"

module mctl_assertions import mctl_pkg::*; (
  input logic                clk,
  input logic                arst_n_i,
  input logic                ctrl_wr_i,
  input logic [`MCTL_DW-1:0] wrdata_i,
  input logic [3:0]          ctrl_q_i,
  input logic                clear_req_i,
  input logic                trip_q_i,
  input logic                motor_ena_i,
  input logic [`MCTL_DW-1:0] cfg0_i,
  input logic [`MCTL_DW-1:0] cfg1_i,
  input logic [`MCTL_DW-1:0] cfg2_i,
  input logic [`MCTL_DW-1:0] div_i,
  input logic                trip_pulse_i,
  input logic                wd_dis_i,
  input logic [`MCTL_DW-1:0] wd_cnt_i,
  input mctl_wd_state_e      wd_state_i
);

  // Low nibble of a CTRL write shows up one edge later
  ctrl_write_lands: assert property (@(posedge clk) disable iff (!arst_n_i)
    ctrl_wr_i |=> (ctrl_q_i == $past(wrdata_i[3:0])))
    else $error("CTRL write did not reach the control register");

  // Clear code beats a trip pulse in the same cycle
  clear_beats_trip: assert property (@(posedge clk) disable iff (!arst_n_i)
    clear_req_i |=> !trip_q_i)
    else $error("clear code did not clear the trip flag");

  config_frozen: assert property (@(posedge clk) disable iff (!arst_n_i)
    motor_ena_i |=> ($stable(cfg0_i) && $stable(cfg1_i) && $stable(cfg2_i) && $stable(div_i)))
    else $error("configuration changed while the motor was enabled");

  trip_single_cycle: assert property (@(posedge clk) disable iff (!arst_n_i)
    trip_pulse_i |=> !trip_pulse_i)
    else $error("watchdog trip pulse longer than one cycle");

  // Disabled watchdog sits idle with a cleared counter
  counter_held: assert property (@(posedge clk) disable iff (!arst_n_i)
    wd_dis_i |=> ((wd_cnt_i == '0) && (wd_state_i == WD_IDLE)))
    else $error("watchdog counter moved while disabled");

endmodule

// Register checks with the watchdog ports tied off
bind mctl_regs mctl_assertions chk_regs (
  .clk          (clk),
  .arst_n_i     (arst_n_i),
  .ctrl_wr_i    (ctrl_wr),
  .wrdata_i     (wrdata_i),
  .ctrl_q_i     (ctrl_q),
  .clear_req_i  (clear_req),
  .trip_q_i     (trip_q),
  .motor_ena_i  (motor_ena),
  .cfg0_i       (cfg_q[0]),
  .cfg1_i       (cfg_q[1]),
  .cfg2_i       (cfg_q[2]),
  .div_i        (div_q),
  .trip_pulse_i (1'b0),
  .wd_dis_i     (1'b0),
  .wd_cnt_i     ('0),
  .wd_state_i   (mctl_pkg::WD_IDLE)
);

// Watchdog checks with the register ports tied off
bind mctl_wd_timer mctl_assertions chk_wd (
  .clk          (clk),
  .arst_n_i     (arst_n_i),
  .ctrl_wr_i    (1'b0),
  .wrdata_i     ('0),
  .ctrl_q_i     ('0),
  .clear_req_i  (1'b0),
  .trip_q_i     (1'b0),
  .motor_ena_i  (1'b0),
  .cfg0_i       ('0),
  .cfg1_i       ('0),
  .cfg2_i       ('0),
  .div_i        ('0),
  .trip_pulse_i (trip_q),
  .wd_dis_i     (disable_i),
  .wd_cnt_i     (cnt_q),
  .wd_state_i   (state_q)
);

// ==== mctl_clkgen.sv ====
////////////////////
// Testbench clock and reset source
////////////////////

`timescale 1ns/1ps

module mctl_clkgen (
  output logic clk_o,
  output logic arst_n_o
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Reset held for 16 cycles, released away from the rising edge
  initial begin
    arst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// ==== mctl_config.svh ====
////////////////////
// Widths, constants and tap lengths
// for the motor control block
////////////////////

`ifndef MCTL_CONFIG_SVH
`define MCTL_CONFIG_SVH

// Register data width
`define MCTL_DW 8

// Number of motor channels
`define MCTL_NCH 3

// Value returned by the identifier register
`define MCTL_HWID_VAL 8'h30

// CTRL write that clears a watchdog trip
`define MCTL_WD_CLEAR 8'h80

// Base ticks per fast tick
`define MCTL_TAP_FAST 64

// Base ticks per slow tick
`define MCTL_TAP_SLOW 16384

// Heartbeat counter width with the LED on its top bit
`define MCTL_LED_BITS 10

`endif

// ==== mctl_pkg.sv ====
////////////////////
// Register address and watchdog
// state types
////////////////////

package mctl_pkg;

  // Register map of the control port
  typedef enum logic [2:0] {
    // Run bits, motor enable, status on read
    MCTL_CTRL  = 3'd0,
    // Per channel phase and PWM inversion
    MCTL_CFG0  = 3'd1,
    MCTL_CFG1  = 3'd2,
    MCTL_CFG2  = 3'd3,
    // Watchdog tick count before a trip
    MCTL_WDDIV = 3'd4,
    // Read only
    MCTL_HWID  = 3'd5
  } mctl_reg_addr_e;

  // Watchdog FSM
  typedef enum logic [1:0] {
    // Disabled or serviced, counter cleared
    WD_IDLE  = 2'd0,
    // Counting ticks
    WD_COUNT = 2'd1,
    // Single cycle with the trip pulse high
    WD_TRIP  = 2'd2
  } mctl_wd_state_e;

endpackage

// ==== mctl_regs.sv ====
////////////////////
// Register file, trip flag, write lock
// and readback mux
////////////////////

`timescale 1ns/1ps

`include "mctl_config.svh"

module mctl_regs import mctl_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 wr_i,
  input  mctl_reg_addr_e       addr_i,
  input  logic [`MCTL_DW-1:0]  wrdata_i,
  input  logic                 wdog_dis_i,
  input  logic                 wd_trip_pulse_i,
  output logic [`MCTL_DW-1:0]  rddata_o,
  output logic [`MCTL_NCH-1:0] run_o,
  output logic                 motor_ena_o,
  output logic [`MCTL_NCH-1:0] inv_phase_o,
  output logic [`MCTL_NCH-1:0] invert_pwm_o,
  output logic                 wd_kick_o,
  output logic [`MCTL_DW-1:0]  wd_div_o,
  output logic                 wd_trip_o
);

  // Bit positions
  localparam int ENA_BIT       = 3;
  localparam int INV_PWM_BIT   = 4;
  localparam int INV_PHASE_BIT = 5;

  logic [ENA_BIT:0]      ctrl_q;
  logic [`MCTL_DW-1:0]   cfg_q [`MCTL_NCH];
  logic [`MCTL_DW-1:0]   div_q;
  logic                  trip_q;
  logic                  motor_ena;
  logic                  ctrl_wr;
  logic                  clear_req;
  logic                  div_wr;
  logic [`MCTL_NCH-1:0]  cfg_wr;

  // Enable as seen by the outside world
  assign motor_ena = ctrl_q[ENA_BIT] && !trip_q;

  assign ctrl_wr   = wr_i && (addr_i == MCTL_CTRL);
  assign clear_req = ctrl_wr && (wrdata_i == `MCTL_WD_CLEAR);

  // Config and divisor are frozen while the motor runs
  assign div_wr = wr_i && (addr_i == MCTL_WDDIV) && !motor_ena;

  for (genvar ch = 0; ch < `MCTL_NCH; ch++) begin : g_chan
    localparam logic [2:0] CFG_ADDR = 3'(int'(MCTL_CFG0) + ch);

    assign cfg_wr[ch]       = wr_i && (addr_i == CFG_ADDR) && !motor_ena;
    assign inv_phase_o[ch]  = cfg_q[ch][INV_PHASE_BIT];
    assign invert_pwm_o[ch] = cfg_q[ch][INV_PWM_BIT];
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_q <= '0;
      div_q  <= '0;
      for (int i = 0; i < `MCTL_NCH; i++) begin
        cfg_q[i] <= '0;
      end
    end else begin
      if (ctrl_wr) begin
        ctrl_q <= wrdata_i[ENA_BIT:0];
      end
      if (div_wr) begin
        div_q <= wrdata_i;
      end
      for (int i = 0; i < `MCTL_NCH; i++) begin
        if (cfg_wr[i]) begin
          cfg_q[i] <= wrdata_i;
        end
      end
    end
  end

  // Clear code has priority over a new trip
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      trip_q <= 1'b0;
    end else if (clear_req) begin
      trip_q <= 1'b0;
    end else if (wd_trip_pulse_i) begin
      trip_q <= 1'b1;
    end
  end

  // Readback
  always_comb begin
    case (addr_i)
      MCTL_CTRL:  rddata_o = {trip_q, wdog_dis_i, 2'b00, ctrl_q};
      MCTL_CFG0:  rddata_o = cfg_q[0];
      MCTL_CFG1:  rddata_o = cfg_q[1];
      MCTL_CFG2:  rddata_o = cfg_q[2];
      MCTL_WDDIV: rddata_o = div_q;
      MCTL_HWID:  rddata_o = `MCTL_HWID_VAL;
      default:    rddata_o = '0;
    endcase
  end

  assign run_o       = ctrl_q[`MCTL_NCH-1:0];
  assign motor_ena_o = motor_ena;
  // Every CTRL write services the watchdog
  assign wd_kick_o   = ctrl_wr;
  assign wd_div_o    = div_q;
  assign wd_trip_o   = trip_q;

endmodule

// ==== mctl_tb.sv ====
////////////////////
// Directed testbench for the motor
// control block
////////////////////

`timescale 1ns/1ps

`include "mctl_config.svh"

module mctl_tb import mctl_pkg::*; ();

  localparam int DW  = `MCTL_DW;
  localparam int NCH = `MCTL_NCH;

  logic           clk;
  logic           arst_n;
  logic           wr;
  mctl_reg_addr_e addr;
  logic [DW-1:0]  wrdata;
  logic           wdog_dis;
  logic           tst;
  logic [1:0]     presc_sel;
  logic [DW-1:0]  rddata;
  logic [NCH-1:0] run;
  logic           motor_ena;
  logic [NCH-1:0] inv_phase;
  logic [NCH-1:0] invert_pwm;
  logic           wd_trip;
  logic           led_alive;

  integer         seed;
  // Expected register contents
  logic [DW-1:0]  cfg_exp [NCH];
  logic [DW-1:0]  div_exp;

  mctl_clkgen u_clkgen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  mctl_top dut_i (
    .clk          (clk),
    .arst_n_i     (arst_n),
    .wr_i         (wr),
    .addr_i       (addr),
    .wrdata_i     (wrdata),
    .wdog_dis_i   (wdog_dis),
    .tst_i        (tst),
    .presc_sel_i  (presc_sel),
    .rddata_o     (rddata),
    .run_o        (run),
    .motor_ena_o  (motor_ena),
    .inv_phase_o  (inv_phase),
    .invert_pwm_o (invert_pwm),
    .wd_trip_o    (wd_trip),
    .led_alive_o  (led_alive)
  );

  task automatic abort_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input logic [DW-1:0] exp,
                            input logic [DW-1:0] act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_vec(input string name, input logic [NCH-1:0] exp,
                           input logic [NCH-1:0] act);
    if (act !== exp) begin
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // Inputs change 5 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic write_reg(input mctl_reg_addr_e a, input logic [DW-1:0] d);
    wr     = 1'b1;
    addr   = a;
    wrdata = d;
    next_cycle();
    wr = 1'b0;
  endtask

  task automatic read_reg(input mctl_reg_addr_e a, output logic [DW-1:0] d);
    addr = a;
    #1;
    d = rddata;
  endtask

  function automatic mctl_reg_addr_e cfg_addr(input int ch);
    case (ch)
      0:       return MCTL_CFG0;
      1:       return MCTL_CFG1;
      default: return MCTL_CFG2;
    endcase
  endfunction

  // One bit of every expected channel config
  function automatic logic [NCH-1:0] cfg_bits(input int pos);
    logic [NCH-1:0] v;
    for (int ch = 0; ch < NCH; ch++) begin
      v[ch] = cfg_exp[ch][pos];
    end
    return v;
  endfunction

  task automatic wait_reset();
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < 40 && !seen; i++) begin
      next_cycle();
      seen = arst_n;
    end
    if (!seen) begin
      $display("Timeout: reset was never released");
      abort_run();
    end
  endtask

  task automatic wait_trip(input int limit);
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < limit && !seen; i++) begin
      next_cycle();
      seen = wd_trip;
    end
    if (!seen) begin
      $display("Timeout: watchdog did not trip within %0d cycles", limit);
      abort_run();
    end
  endtask

  task automatic reset_values();
    logic [DW-1:0] rd;
    check_vec("reset run", '0, run);
    check_bit("reset motor_ena", 1'b0, motor_ena);
    check_vec("reset inv_phase", '0, inv_phase);
    check_vec("reset invert_pwm", '0, invert_pwm);
    check_bit("reset wd_trip", 1'b0, wd_trip);
    check_bit("reset led_alive", 1'b0, led_alive);
    read_reg(MCTL_HWID, rd);
    check_data("reset hwid", 8'h30, rd);
    read_reg(MCTL_CTRL, rd);
    check_data("reset status", '0, rd);
    for (int ch = 0; ch < NCH; ch++) begin
      cfg_exp[ch] = '0;
      read_reg(cfg_addr(ch), rd);
      check_data("reset cfg", '0, rd);
    end
    div_exp = '0;
    read_reg(MCTL_WDDIV, rd);
    check_data("reset wddiv", '0, rd);
  endtask

  task automatic cfg_readback();
    logic [DW-1:0] val;
    logic [DW-1:0] rd;
    for (int ch = 0; ch < NCH; ch++) begin
      val = $random(seed);
      cfg_exp[ch] = val;
      write_reg(cfg_addr(ch), val);
    end
    div_exp = $random(seed);
    write_reg(MCTL_WDDIV, div_exp);
    for (int ch = 0; ch < NCH; ch++) begin
      read_reg(cfg_addr(ch), rd);
      check_data("cfg_readback cfg", cfg_exp[ch], rd);
    end
    read_reg(MCTL_WDDIV, rd);
    check_data("cfg_readback wddiv", div_exp, rd);
    // Bit 5 is phase invert, bit 4 PWM invert
    check_vec("cfg_readback inv_phase", cfg_bits(5), inv_phase);
    check_vec("cfg_readback invert_pwm", cfg_bits(4), invert_pwm);
    repeat (4) begin
      val = $random(seed) & 8'h77;
      write_reg(MCTL_CTRL, val);
      check_vec("cfg_readback run", val[NCH-1:0], run);
      check_bit("cfg_readback motor_ena", 1'b0, motor_ena);
      read_reg(MCTL_CTRL, rd);
      check_data("cfg_readback status", {4'h0, val[3:0]}, rd);
    end
  endtask

  task automatic cfg_lock();
    logic [DW-1:0] val;
    logic [DW-1:0] rd;
    // Large divisor so the watchdog stays quiet on the slow tap
    div_exp = 8'hf0 | $random(seed);
    write_reg(MCTL_WDDIV, div_exp);
    val = 8'h08 | ($random(seed) & 8'h07);
    write_reg(MCTL_CTRL, val);
    check_bit("cfg_lock motor_ena", 1'b1, motor_ena);
    check_vec("cfg_lock run", val[NCH-1:0], run);
    for (int ch = 0; ch < NCH; ch++) begin
      write_reg(cfg_addr(ch), ~cfg_exp[ch]);
    end
    write_reg(MCTL_WDDIV, ~div_exp);
    for (int ch = 0; ch < NCH; ch++) begin
      read_reg(cfg_addr(ch), rd);
      check_data("cfg_lock cfg", cfg_exp[ch], rd);
    end
    read_reg(MCTL_WDDIV, rd);
    check_data("cfg_lock wddiv", div_exp, rd);
    check_vec("cfg_lock inv_phase", cfg_bits(5), inv_phase);
    check_vec("cfg_lock invert_pwm", cfg_bits(4), invert_pwm);
    write_reg(MCTL_CTRL, 8'h00);
    check_bit("cfg_lock motor off", 1'b0, motor_ena);
  endtask

  task automatic wd_trip_clear();
    logic [DW-1:0] rd;
    tst       = 1'b1;
    presc_sel = 2'd0;
    write_reg(MCTL_WDDIV, 8'd3);
    write_reg(MCTL_CTRL, 8'h08);
    check_bit("wd_trip_clear motor_ena", 1'b1, motor_ena);
    wait_trip((3 + 2) * 64 + 4);
    check_bit("wd_trip_clear motor dropped", 1'b0, motor_ena);
    read_reg(MCTL_CTRL, rd);
    check_bit("wd_trip_clear status bit 7", 1'b1, rd[7]);
    check_data("wd_trip_clear status", 8'h88, rd);
    write_reg(MCTL_CTRL, `MCTL_WD_CLEAR);
    check_bit("wd_trip_clear wd_trip", 1'b0, wd_trip);
    read_reg(MCTL_CTRL, rd);
    check_data("wd_trip_clear ctrl", 8'h00, rd);
  endtask

  task automatic wd_service();
    logic [DW-1:0] rd;
    wdog_dis = 1'b1;
    write_reg(MCTL_CTRL, 8'h08);
    read_reg(MCTL_CTRL, rd);
    check_data("wd_service status", 8'h48, rd);
    for (int i = 0; i < 2000; i++) begin
      next_cycle();
      check_bit("wd_service disabled", 1'b0, wd_trip);
    end
    // Kicks every 100 cycles stay well inside four fast ticks
    wdog_dis = 1'b0;
    for (int i = 0; i < 2000; i++) begin
      wr     = (i % 100 == 0);
      addr   = MCTL_CTRL;
      wrdata = 8'h08;
      next_cycle();
      check_bit("wd_service kicked", 1'b0, wd_trip);
    end
    wr = 1'b0;
    check_bit("wd_service motor_ena", 1'b1, motor_ena);
    write_reg(MCTL_CTRL, 8'h00);
  endtask

  task automatic led_heartbeat();
    logic start;
    bit   seen;
    int   limit;
    presc_sel = 2'd1;
    limit     = 512 * 64 * 2 + 16;
    seen      = 1'b0;
    next_cycle();
    start = led_alive;
    for (int i = 0; i < limit && !seen; i++) begin
      next_cycle();
      seen = (led_alive !== start);
    end
    if (!seen) begin
      $display("Timeout: heartbeat LED did not toggle within %0d cycles", limit);
      abort_run();
    end
  endtask

  initial begin
    seed      = 80;
    wr        = 1'b0;
    addr      = MCTL_CTRL;
    wrdata    = '0;
    wdog_dis  = 1'b0;
    tst       = 1'b0;
    presc_sel = 2'd0;
    wait_reset();
    reset_values();
    cfg_readback();
    cfg_lock();
    wd_trip_clear();
    wd_service();
    led_heartbeat();
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== mctl_timebase.sv ====
////////////////////
// Prescaler, fast and slow tick taps
// and heartbeat LED counter
////////////////////

`timescale 1ns/1ps

`include "mctl_config.svh"

module mctl_timebase (
  input  logic       clk,
  input  logic       arst_n_i,
  input  logic [1:0] presc_sel_i,
  output logic       tick_fast_o,
  output logic       tick_slow_o,
  output logic       led_alive_o
);

  localparam int FAST_W = $clog2(`MCTL_TAP_FAST);
  localparam int SLOW_W = $clog2(`MCTL_TAP_SLOW / `MCTL_TAP_FAST);
  localparam logic [FAST_W-1:0] FAST_LAST = FAST_W'(`MCTL_TAP_FAST - 1);
  localparam logic [SLOW_W-1:0] SLOW_LAST = SLOW_W'(`MCTL_TAP_SLOW / `MCTL_TAP_FAST - 1);

  logic [2:0]                presc_q;
  logic                      base_tick;
  logic [FAST_W-1:0]         fast_cnt_q;
  logic [SLOW_W-1:0]         slow_cnt_q;
  logic                      fast_q;
  logic                      slow_q;
  logic [`MCTL_LED_BITS-1:0] led_cnt_q;

  // Free running prescaler
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      presc_q <= '0;
    end else begin
      presc_q <= presc_q + 3'd1;
    end
  end

  // Divide by 1, 2, 4 or 8
  always_comb begin
    case (presc_sel_i)
      2'd0:    base_tick = 1'b1;
      2'd1:    base_tick = presc_q[0];
      2'd2:    base_tick = &presc_q[1:0];
      default: base_tick = &presc_q;
    endcase
  end

  // Fast tap counts base ticks, slow tap counts fast ticks
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fast_cnt_q <= '0;
      slow_cnt_q <= '0;
      fast_q     <= 1'b0;
      slow_q     <= 1'b0;
    end else begin
      fast_q <= base_tick && (fast_cnt_q == FAST_LAST);
      slow_q <= fast_q && (slow_cnt_q == SLOW_LAST);
      if (base_tick) begin
        fast_cnt_q <= fast_cnt_q + 1'b1;
      end
      if (fast_q) begin
        slow_cnt_q <= slow_cnt_q + 1'b1;
      end
    end
  end

  // Heartbeat
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      led_cnt_q <= '0;
    end else if (fast_q) begin
      led_cnt_q <= led_cnt_q + 1'b1;
    end
  end

  assign tick_fast_o = fast_q;
  assign tick_slow_o = slow_q;
  assign led_alive_o = led_cnt_q[`MCTL_LED_BITS-1];

endmodule

// ==== mctl_top.sv ====
////////////////////
// Motor control top level
////////////////////

`timescale 1ns/1ps

`include "mctl_config.svh"

module mctl_top import mctl_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 wr_i,
  input  mctl_reg_addr_e       addr_i,
  input  logic [`MCTL_DW-1:0]  wrdata_i,
  input  logic                 wdog_dis_i,
  input  logic                 tst_i,
  input  logic [1:0]           presc_sel_i,
  output logic [`MCTL_DW-1:0]  rddata_o,
  output logic [`MCTL_NCH-1:0] run_o,
  output logic                 motor_ena_o,
  output logic [`MCTL_NCH-1:0] inv_phase_o,
  output logic [`MCTL_NCH-1:0] invert_pwm_o,
  output logic                 wd_trip_o,
  output logic                 led_alive_o
);

  logic                motor_ena;
  logic                wd_kick;
  logic [`MCTL_DW-1:0] wd_div;
  logic                wd_trip_pulse;
  logic                tick_fast;
  logic                tick_slow;
  logic                wd_tick;

  mctl_regs u_regs (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .wr_i            (wr_i),
    .addr_i          (addr_i),
    .wrdata_i        (wrdata_i),
    .wdog_dis_i      (wdog_dis_i),
    .wd_trip_pulse_i (wd_trip_pulse),
    .rddata_o        (rddata_o),
    .run_o           (run_o),
    .motor_ena_o     (motor_ena),
    .inv_phase_o     (inv_phase_o),
    .invert_pwm_o    (invert_pwm_o),
    .wd_kick_o       (wd_kick),
    .wd_div_o        (wd_div),
    .wd_trip_o       (wd_trip_o)
  );

  mctl_timebase u_timebase (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .presc_sel_i (presc_sel_i),
    .tick_fast_o (tick_fast),
    .tick_slow_o (tick_slow),
    .led_alive_o (led_alive_o)
  );

  // Test mode runs the watchdog from the fast tap
  assign wd_tick = tst_i ? tick_fast : tick_slow;

  mctl_wd_timer u_wd_timer (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .tick_i       (wd_tick),
    .enable_i     (motor_ena),
    .kick_i       (wd_kick),
    .disable_i    (wdog_dis_i),
    .div_i        (wd_div),
    .trip_pulse_o (wd_trip_pulse)
  );

  assign motor_ena_o = motor_ena;

endmodule

// ==== mctl_wd_timer.sv ====
////////////////////
// Watchdog counter, FSM and
// registered trip pulse
////////////////////

`timescale 1ns/1ps

`include "mctl_config.svh"

module mctl_wd_timer import mctl_pkg::*; (
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               tick_i,
  input  logic               enable_i,
  input  logic               kick_i,
  input  logic               disable_i,
  input  logic [`MCTL_DW-1:0] div_i,
  output logic               trip_pulse_o
);

  mctl_wd_state_e     state_q;
  logic [`MCTL_DW-1:0] cnt_q;
  logic               trip_q;
  logic               hold;
  logic               expire;

  // Kick, disable or motor off keeps the counter cleared
  assign hold   = kick_i || disable_i || !enable_i;
  assign expire = tick_i && (cnt_q == div_i);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= WD_IDLE;
      cnt_q   <= '0;
      trip_q  <= 1'b0;
    end else begin
      trip_q <= 1'b0;
      if (hold) begin
        state_q <= WD_IDLE;
        cnt_q   <= '0;
      end else begin
        case (state_q)
          WD_IDLE, WD_COUNT: begin
            // Tick in the first cycle after a kick still counts
            state_q <= WD_COUNT;
            if (expire) begin
              state_q <= WD_TRIP;
              trip_q  <= 1'b1;
            end else if (tick_i) begin
              cnt_q <= cnt_q + 1'b1;
            end
          end
          WD_TRIP: begin
            // Trip flag drops the enable next, so park here
            state_q <= WD_IDLE;
            cnt_q   <= '0;
          end
          default: begin
            state_q <= WD_IDLE;
            cnt_q   <= '0;
          end
        endcase
      end
    end
  end

  assign trip_pulse_o = trip_q;

endmodule

// ==== vlog.f ====
+incdir+.
mctl_pkg.sv
mctl_timebase.sv
mctl_wd_timer.sv
mctl_regs.sv
mctl_top.sv
mctl_assertions.sv
mctl_clkgen.sv
mctl_tb.sv
